// File: bench/busChecker.sv
`timescale 1ns/1ps

module busChecker import cpuPkg::*; (
    input logic CLK,
    input logic RESET,
    input byteT busAddr,
    input byteT busData,
    input logic busWe,
    input byteT romAddr,
    input logic [irqCount-1:0] irqRaise,
    input logic [irqCount-1:0] irqAck,
    output int mismatchCount,
    output int otherCount,
    output int pendingCount
);

    // Guards the model against a runaway program
    localparam int stepLimit = 4000;

    // One bus write as the model predicts it
    typedef struct packed {
        byteT addr;
        byteT data;
    } writeT;

    // Model copies of program ROM and data RAM
    byteT romCopy [0:255];
    byteT ramCopy [0:127];
    // Architectural state, carried from thread to thread
    byteT modelA;
    byteT modelB;
    byteT modelContext;
    // Predicted writes, oldest first
    writeT expected [$];

    initial begin
        mismatchCount = 0;
        otherCount = 0;
        pendingCount = 0;
        // A and B leave reset as zero
        modelA = '0;
        modelB = '0;
        modelContext = '0;
    end

    task automatic storeRom(input byteT addr, input byteT value);
        romCopy[addr] = value;
    endtask

    task automatic storeRam(input logic [6:0] addr, input byteT value);
        ramCopy[addr] = value;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Instruction-level model
    ////////////////////////////////////////////////////////////////////////////

    // Upper nibble table, compares give 1 or 0
    function automatic byteT aluModel(input logic [3:0] code, input byteT a, input byteT b);
        case (aluOpT'(code))
            aluAdd: return a + b;
            aluSub: return a - b;
            aluMul: return a * b;
            aluShl: return a << 1;
            aluShr: return a >> 1;
            aluIncA: return a + 8'd1;
            aluIncB: return b + 8'd1;
            aluDecA: return a - 8'd1;
            aluDecB: return b - 8'd1;
            aluEq: return (a == b) ? 8'd1 : 8'd0;
            aluGt: return (a > b) ? 8'd1 : 8'd0;
            aluLt: return (a < b) ? 8'd1 : 8'd0;
            default: return a;
        endcase
    endfunction

    // Upper half of the bus space reads as zero
    function automatic byteT readMem(input byteT addr);
        return addr[7] ? 8'h00 : ramCopy[addr[6:0]];
    endfunction

    task automatic writeMem(input byteT addr, input byteT value);
        expected.push_back({addr, value});
        if (!addr[7]) begin
            ramCopy[addr[6:0]] = value;
        end
    endtask

    task automatic setReg(input logic toB, input byteT value);
        if (toB) begin
            modelB = value;
        end else begin
            modelA = value;
        end
    endtask

    // Walks one thread from its start to endThread
    task automatic runThread(input byteT start);
        byteT pc;
        byteT inst;
        byteT operand;
        int steps;
        logic done;
        pc = start;
        steps = 0;
        done = 1'b0;
        while (!done) begin
            inst = romCopy[pc];
            operand = romCopy[pc + 8'd1];
            steps++;
            case (opcodeT'(inst[3:0]))
                readA, readB: begin
                    setReg(inst[3:0] == readB, readMem(operand));
                    pc = pc + 8'd2;
                end
                writeA, writeB: begin
                    writeMem(operand, (inst[3:0] == writeB) ? modelB : modelA);
                    pc = pc + 8'd2;
                end
                mathsA, mathsB: begin
                    setReg(inst[3:0] == mathsB, aluModel(inst[7:4], modelA, modelB));
                    pc = pc + 8'd1;
                end
                // Taken on any nonzero result
                branchIf: begin
                    if (aluModel(inst[7:4], modelA, modelB) != 8'd0) begin
                        pc = operand;
                    end else begin
                        pc = pc + 8'd2;
                    end
                end
                goTo: pc = operand;
                endThread: done = 1'b1;
                // Single saved context, return lands after the call
                call: begin
                    modelContext = pc + 8'd2;
                    pc = operand;
                end
                ret: pc = modelContext;
                derefA: begin
                    modelA = readMem(modelA);
                    pc = pc + 8'd1;
                end
                derefB: begin
                    modelB = readMem(modelB);
                    pc = pc + 8'd1;
                end
                loadImmA, loadImmB: begin
                    setReg(inst[3:0] == loadImmB, operand);
                    pc = pc + 8'd2;
                end
                default: begin
                    otherCount++;
                    $display("Model reached the unused opcode at ROM address %h", pc);
                    done = 1'b1;
                end
            endcase
            if (!done && steps >= stepLimit) begin
                otherCount++;
                $display("Model ran past its step limit in the thread at %h", start);
                done = 1'b1;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Port monitor
    ////////////////////////////////////////////////////////////////////////////

    task automatic checkWrite();
        writeT want;
        if (expected.size() == 0) begin
            otherCount++;
            $display("Unexpected bus write of %h to address %h", busData, busAddr);
        end else begin
            want = expected.pop_front();
            if (busAddr !== want.addr) begin
                mismatchCount++;
                $display("Mismatch busAddr: expected %h, got %h", want.addr, busAddr);
            end
            if (busData !== want.data) begin
                mismatchCount++;
                $display("Mismatch busData: expected %h, got %h", want.data, busData);
            end
        end
        pendingCount = expected.size();
    endtask

    task automatic serveAck();
        logic [irqCount-1:0] wantAck;
        byteT wantVector;
        // Line 0 wins when both are raised
        wantAck = irqRaise[0] ? 2'b01 : 2'b10;
        wantVector = wantAck[0] ? irqVector0 : irqVector1;
        if (irqAck !== wantAck) begin
            mismatchCount++;
            $display("Mismatch irqAck: expected %h, got %h", wantAck, irqAck);
        end
        // ROM points at the vector cell while the acknowledge pulses
        if (romAddr !== wantVector) begin
            mismatchCount++;
            $display("Mismatch romAddr: expected %h, got %h", wantVector, romAddr);
        end
        // The thread before must have made all its writes
        if (expected.size() != 0) begin
            otherCount++;
            $display("Thread ended with %0d predicted writes never seen", expected.size());
            expected.delete();
        end
        runThread(romCopy[wantVector]);
        pendingCount = expected.size();
    endtask

    // Falling edge, all DUT outputs settled
    always @(negedge CLK) begin
        if (RESET) begin
            if (busWe !== 1'b0) begin
                mismatchCount++;
                $display("Mismatch busWe: expected %h, got %h", 1'b0, busWe);
            end
            if (irqAck !== '0) begin
                mismatchCount++;
                $display("Mismatch irqAck: expected %h, got %h", 2'b00, irqAck);
            end
            if (busAddr !== idleBusAddr) begin
                mismatchCount++;
                $display("Mismatch busAddr: expected %h, got %h", idleBusAddr, busAddr);
            end
            // Program counter starts at zero
            if (romAddr !== 8'h00) begin
                mismatchCount++;
                $display("Mismatch romAddr: expected %h, got %h", 8'h00, romAddr);
            end
        end else begin
            if (busWe === 1'b1) begin
                checkWrite();
            end else if (busWe !== 1'b0) begin
                otherCount++;
                $display("Write enable is unknown after reset");
            end
            if (irqAck !== '0) begin
                serveAck();
            end
        end
    end

endmodule

// File: bench/processorBench.sv
`timescale 1ns/1ps

module processorBench import cpuPkg::*; ();

    localparam int threadRounds = 24;
    localparam int waitLimit = 4000;
    // ROM layout, two threads then two subroutines
    localparam byteT thread0Start = 8'h01;
    localparam byteT thread1Start = 8'h50;
    localparam byteT sub0Start = 8'hA0;
    localparam byteT sub1Start = 8'hCC;
    localparam byteT subEnd = 8'hF8;

    logic CLK;
    logic RESET;
    logic [irqCount-1:0] irqRaise;
    logic [irqCount-1:0] irqAck;
    wire [dataWidth-1:0] busData;
    byteT busAddr;
    logic busWe;
    byteT romAddr;
    byteT romData;

    byteT rom [0:255];
    byteT ram [0:127];
    byteT genAddr;
    int timeoutCount;
    int mismatchCount;
    int otherCount;
    int pendingCount;

    // Program ROM and RAM answer combinationally
    assign romData = rom[romAddr];
    assign busData = busWe ? 8'hzz : (busAddr[7] ? 8'h00 : ram[busAddr[6:0]]);

    always @(posedge CLK) begin
        if (busWe === 1'b1 && !busAddr[7]) begin
            ram[busAddr[6:0]] <= busData;
        end
    end

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    microProcessor i_microProcessor (
        .CLK(CLK),
        .RESET(RESET),
        .busData(busData),
        .busAddr(busAddr),
        .busWe(busWe),
        .romAddr(romAddr),
        .romData(romData),
        .irqRaise(irqRaise),
        .irqAck(irqAck)
    );

    busChecker i_busChecker (
        .CLK(CLK),
        .RESET(RESET),
        .busAddr(busAddr),
        .busData(busData),
        .busWe(busWe),
        .romAddr(romAddr),
        .irqRaise(irqRaise),
        .irqAck(irqAck),
        .mismatchCount(mismatchCount),
        .otherCount(otherCount),
        .pendingCount(pendingCount)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Program generation
    ////////////////////////////////////////////////////////////////////////////

    function automatic byteT randomOperand(input int range);
        return $urandom % range;
    endfunction

    // Opcode with a random upper nibble as ALU select
    function automatic byteT opByte(input logic [3:0] code);
        logic [3:0] upper;
        upper = $urandom % 16;
        return {upper, code};
    endfunction

    task automatic putByte(input byteT value);
        rom[genAddr] = value;
        genAddr = genAddr + 8'd1;
    endtask

    task automatic putPair(input byteT value, input byteT operand);
        putByte(value);
        putByte(operand);
    endtask

    // Forward jumps only, subroutines hold no call
    task automatic genBlock(input byteT start, input byteT limit, input logic isSub);
        int kind;
        genAddr = start;
        while (genAddr + 6 < limit) begin
            kind = $urandom % 14;
            case (kind)
                0: putPair(opByte(readA), randomOperand(160));
                1: putPair(opByte(readB), randomOperand(160));
                2, 13: putPair(opByte(writeA), randomOperand(144));
                3: putPair(opByte(writeB), randomOperand(144));
                4: putByte(opByte(mathsA));
                5: putByte(opByte(mathsB));
                // Target skips the write placed right behind
                6, 7: begin
                    putPair(opByte(kind == 6 ? branchIf : goTo), genAddr + 8'd4);
                    putPair(opByte(writeA), randomOperand(144));
                end
                8: begin
                    if (isSub) begin
                        putPair(opByte(writeB), randomOperand(144));
                    end else begin
                        putPair(opByte(call), ($urandom % 2) ? sub1Start : sub0Start);
                    end
                end
                9: putByte(opByte(derefA));
                10: putByte(opByte(derefB));
                11: putPair(opByte(loadImmA), randomOperand(192));
                default: putPair(opByte(loadImmB), randomOperand(192));
            endcase
        end
        putByte(opByte(isSub ? ret : endThread));
    endtask

    task automatic waitForAck();
        int cycles;
        cycles = 0;
        while (irqAck === '0 && cycles < waitLimit) begin
            @(negedge CLK);
            cycles++;
        end
        if (irqAck === '0) begin
            timeoutCount++;
            $display("Timeout waiting for an interrupt acknowledge");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        int cycles;
        logic [irqCount-1:0] pattern;
        void'($urandom(64235));
        RESET = 1'b1;
        irqRaise = '0;
        timeoutCount = 0;
        // Unused ROM ends a thread, address 0 too
        for (int i = 0; i < 256; i++) begin
            rom[i] = {4'h0, endThread};
        end
        for (int i = 0; i < 128; i++) begin
            ram[i] = $urandom;
        end
        genBlock(thread0Start, thread1Start, 1'b0);
        genBlock(thread1Start, sub0Start, 1'b0);
        genBlock(sub0Start, sub1Start, 1'b1);
        genBlock(sub1Start, subEnd, 1'b1);
        rom[irqVector0] = thread0Start;
        rom[irqVector1] = thread1Start;
        for (int i = 0; i < 256; i++) begin
            i_busChecker.storeRom(i[7:0], rom[i]);
        end
        for (int i = 0; i < 128; i++) begin
            i_busChecker.storeRam(i[6:0], ram[i]);
        end

        repeat (16) @(posedge CLK);
        #1;
        RESET = 1'b0;

        for (int round = 0; round < threadRounds && timeoutCount == 0; round++) begin
            @(posedge CLK);
            #1;
            // Both lines first, then a random nonzero mix
            pattern = $urandom_range(1, 3);
            irqRaise = (round == 0) ? 2'b11 : pattern;
            waitForAck();
        end

        // Let the last thread finish its writes
        if (timeoutCount == 0) begin
            @(posedge CLK);
            #1;
            irqRaise = '0;
            cycles = 0;
            while (pendingCount != 0 && cycles < waitLimit) begin
                @(posedge CLK);
                cycles++;
            end
            if (pendingCount != 0) begin
                timeoutCount++;
                $display("Timeout waiting for the last thread to make its writes");
            end
        end

        $display("Errors: %0d mismatches, %0d other failures, %0d timeouts",
            mismatchCount, otherCount, timeoutCount);
        if (mismatchCount == 0 && otherCount == 0 && timeoutCount == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: logic/aluUnit.sv
`timescale 1ns/1ps

module aluUnit import cpuPkg::*; (
    input logic CLK,
    input logic RESET,
    input byteT a,
    input byteT b,
    input aluOpT op,
    output byteT result
);

    byteT nextResult;

    //////////////////////////////////////////////////////////////////////////////
    // Operation select
    //////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (op)
            aluAdd: nextResult = a + b;
            aluSub: nextResult = a - b;
            // Low byte of the product only
            aluMul: nextResult = a * b;
            aluShl: nextResult = a << 1;
            aluShr: nextResult = a >> 1;
            aluIncA: nextResult = a + byteT'(1);
            aluIncB: nextResult = b + byteT'(1);
            aluDecA: nextResult = a - byteT'(1);
            aluDecB: nextResult = b - byteT'(1);
            // Compares give a plain 1 or 0 for the branch test
            aluEq: nextResult = (a == b) ? byteT'(1) : byteT'(0);
            aluGt: nextResult = (a > b) ? byteT'(1) : byteT'(0);
            aluLt: nextResult = (a < b) ? byteT'(1) : byteT'(0);
            // Unassigned codes pass A through
            default: nextResult = a;
        endcase
    end

    // One cycle from operands to result
    always_ff @(posedge CLK) begin
        if (RESET) begin
            result <= '0;
        end else begin
            result <= nextResult;
        end
    end

    // Registers and ROM opcode must be resolved once out of reset
    resultKnown: assert property (
        @(posedge CLK) disable iff (RESET) !$isunknown(result)
    );

endmodule

// File: logic/busDatapath.sv
`timescale 1ns/1ps

module busDatapath import cpuPkg::*; (
    input logic CLK,
    input logic RESET,
    input ctrlT ctrl,
    input byteT romData,
    input byteT aluResult,
    inout wire byteT busData,
    output byteT busAddr,
    output logic busWe,
    output byteT regA,
    output byteT regB
);

    byteT loadData;
    byteT nextAddr;
    // Data held for the write strobe
    byteT wrData;

    // Tristate drive only during the strobe
    assign busData = busWe ? wrData : 'z;

    //////////////////////////////////////////////////////////////////////////////
    // Source muxes
    //////////////////////////////////////////////////////////////////////////////

    always_comb begin
        case (ctrl.regSrc)
            srcAlu: loadData = aluResult;
            srcRom: loadData = romData;
            default: loadData = busData;
        endcase
    end

    always_comb begin
        case (ctrl.busAddrSel)
            addrRom: nextAddr = romData;
            addrRegA: nextAddr = regA;
            addrRegB: nextAddr = regB;
            default: nextAddr = idleBusAddr;
        endcase
    end

    //////////////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            regA <= '0;
            regB <= '0;
            busAddr <= idleBusAddr;
            busWe <= 1'b0;
        end else begin
            if (ctrl.loadA) begin
                regA <= loadData;
            end
            if (ctrl.loadB) begin
                regB <= loadData;
            end
            // Address and strobe valid in the same cycle
            busAddr <= nextAddr;
            busWe <= ctrl.busWrite;
        end
    end

    always_ff @(posedge CLK) begin
        if (ctrl.busWrite) begin
            wrData <= ctrl.writeFromB ? regB : regA;
        end
    end

endmodule

// File: logic/controlFsm.sv
`timescale 1ns/1ps

module controlFsm import cpuPkg::*; (
    input logic CLK,
    input logic RESET,
    input byteT romData,
    input byteT aluResult,
    input logic [irqCount-1:0] irqRaise,
    output logic [irqCount-1:0] irqAck,
    output ctrlT ctrl
);

    stateT state;
    stateT nextState;
    // Target register of read and dereference, 1 selects B
    logic regSel;
    logic nextRegSel;
    logic [irqCount-1:0] nextAck;
    opcodeT opcode;

    // Lower nibble of the current ROM byte
    assign opcode = opcodeT'(romData[opWidth-1:0]);

    //////////////////////////////////////////////////////////////////////////////
    // State and acknowledge registers
    //////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            state <= chooseOp;
            regSel <= 1'b0;
            irqAck <= '0;
        end else begin
            state <= nextState;
            regSel <= nextRegSel;
            irqAck <= nextAck;
        end
    end

    //////////////////////////////////////////////////////////////////////////////
    // Next state and control word
    //////////////////////////////////////////////////////////////////////////////

    always_comb begin
        nextState = state;
        nextRegSel = regSel;
        nextAck = '0;
        // Quiet control word by default
        ctrl.pcOp = pcHold;
        ctrl.fetchOffset = 1'b0;
        ctrl.saveContext = 1'b0;
        ctrl.loadA = 1'b0;
        ctrl.loadB = 1'b0;
        ctrl.regSrc = srcBus;
        ctrl.busAddrSel = addrIdle;
        ctrl.busWrite = 1'b0;
        ctrl.writeFromB = 1'b0;
        ctrl.vector = irqVector0;

        case (state)
            // Wait for an interrupt, line 0 wins
            idle: begin
                if (irqRaise[0]) begin
                    nextState = threadStart0;
                    nextAck = 2'b01;
                    ctrl.pcOp = pcLoadVector;
                    ctrl.vector = irqVector0;
                end else if (irqRaise[1]) begin
                    nextState = threadStart0;
                    nextAck = 2'b10;
                    ctrl.pcOp = pcLoadVector;
                    ctrl.vector = irqVector1;
                end
            end
            threadStart0: nextState = threadStart1;
            // ROM now shows the thread start address
            threadStart1: begin
                nextState = threadStart2;
                ctrl.pcOp = pcLoadRom;
            end

            // Decode and point the ROM at the operand byte
            chooseOp: begin
                ctrl.fetchOffset = 1'b1;
                case (opcode)
                    readA: nextState = readToA;
                    readB: nextState = readToB;
                    writeA: nextState = writeMemA;
                    writeB: nextState = writeMemB;
                    mathsA: nextState = mathsToA;
                    mathsB: nextState = mathsToB;
                    branchIf: nextState = branchTest;
                    goTo: nextState = gotoFetch;
                    endThread: nextState = idle;
                    call: nextState = callSave;
                    ret: nextState = retWait;
                    derefA: nextState = derefToA;
                    derefB: nextState = derefToB;
                    loadImmA: nextState = loadImmToA;
                    loadImmB: nextState = loadImmToB;
                    // Code F parks the machine here
                    default: ctrl.fetchOffset = 1'b0;
                endcase
            end

            //////////////////////////////////////////////////////////////////////////////
            // Memory read
            readToA, readToB: begin
                nextState = readAddr;
                nextRegSel = (state == readToB);
                ctrl.fetchOffset = 1'b1;
            end
            // Operand byte becomes the bus address
            readAddr: begin
                nextState = readLoad;
                ctrl.busAddrSel = addrRom;
            end
            // Read data is on the bus this cycle
            readLoad: begin
                nextState = readSettle;
                ctrl.loadA = !regSel;
                ctrl.loadB = regSel;
                ctrl.pcOp = pcPlusTwo;
            end

            // Memory write, strobe lands in writeStrobe
            writeMemA, writeMemB: begin
                nextState = writeStrobe;
                ctrl.busAddrSel = addrRom;
                ctrl.busWrite = 1'b1;
                ctrl.writeFromB = (state == writeMemB);
                ctrl.pcOp = pcPlusTwo;
            end

            // ALU result was registered during chooseOp
            mathsToA, mathsToB: begin
                nextState = mathsSettle;
                ctrl.regSrc = srcAlu;
                ctrl.loadA = (state == mathsToA);
                ctrl.loadB = (state == mathsToB);
                ctrl.pcOp = pcPlusOne;
            end

            //////////////////////////////////////////////////////////////////////////////
            // Branch on nonzero compare
            branchTest: begin
                if (aluResult != '0) begin
                    nextState = branchTake;
                    ctrl.fetchOffset = 1'b1;
                end else begin
                    nextState = branchSettle;
                    ctrl.pcOp = pcPlusTwo;
                end
            end
            branchTake: begin
                nextState = branchSettle;
                ctrl.pcOp = pcLoadRom;
            end

            // Goto and call share the jump
            gotoFetch: begin
                nextState = gotoLoad;
                ctrl.fetchOffset = 1'b1;
            end
            callSave: begin
                nextState = gotoLoad;
                ctrl.fetchOffset = 1'b1;
                ctrl.saveContext = 1'b1;
            end
            gotoLoad: begin
                nextState = gotoSettle;
                ctrl.pcOp = pcLoadRom;
            end
            retWait: nextState = retLoad;
            retLoad: begin
                nextState = retSettle;
                ctrl.pcOp = pcLoadContext;
            end

            //////////////////////////////////////////////////////////////////////////////
            // Dereference through A or B
            derefToA, derefToB: begin
                nextState = derefAddr;
                nextRegSel = (state == derefToB);
            end
            derefAddr: begin
                nextState = derefLoad;
                ctrl.busAddrSel = regSel ? addrRegB : addrRegA;
            end
            derefLoad: begin
                nextState = derefSettle;
                ctrl.loadA = !regSel;
                ctrl.loadB = regSel;
                ctrl.pcOp = pcPlusOne;
            end

            // Immediate is the operand byte
            loadImmToA, loadImmToB: begin
                nextState = loadImmSettle;
                ctrl.regSrc = srcRom;
                ctrl.loadA = (state == loadImmToA);
                ctrl.loadB = (state == loadImmToB);
                ctrl.pcOp = pcPlusTwo;
            end

            // Let the new address settle
            threadStart2, readSettle, writeStrobe, mathsSettle, branchSettle,
            gotoSettle, retSettle, derefSettle, loadImmSettle: begin
                nextState = chooseOp;
            end
            default: nextState = idle;
        endcase
    end

    // Priority logic serves a single line at a time
    ackNotTwoHot: assert property (
        @(posedge CLK) disable iff (RESET) $onehot0(irqAck)
    );

endmodule

// File: logic/cpuPkg.sv
package cpuPkg;

    // Data path and instruction widths
    localparam int dataWidth = 8;
    localparam int opWidth = 4;
    localparam int irqCount = 2;

    // Every data, address and ROM value
    typedef logic [dataWidth-1:0] byteT;

    // Bus address while nothing is addressed
    localparam byteT idleBusAddr = 8'hFF;
    // ROM cells holding the thread start addresses
    localparam byteT irqVector0 = 8'hFF;
    localparam byteT irqVector1 = 8'hFE;

    // Lower instruction nibble, code F is left unused
    typedef enum logic [opWidth-1:0] {
        readA = 4'h0, readB = 4'h1, writeA = 4'h2, writeB = 4'h3,
        mathsA = 4'h4, mathsB = 4'h5, branchIf = 4'h6, goTo = 4'h7,
        endThread = 4'h8, call = 4'h9, ret = 4'hA,
        derefA = 4'hB, derefB = 4'hC, loadImmA = 4'hD, loadImmB = 4'hE
    } opcodeT;

    // Upper instruction nibble, selects the ALU function
    typedef enum logic [opWidth-1:0] {
        aluAdd = 4'h0, aluSub = 4'h1, aluMul = 4'h2, aluShl = 4'h3,
        aluShr = 4'h4, aluIncA = 4'h5, aluIncB = 4'h6, aluDecA = 4'h7,
        aluDecB = 4'h8, aluEq = 4'h9, aluGt = 4'hA, aluLt = 4'hB
    } aluOpT;

    // Controller states, upper nibble groups them by instruction
    typedef enum logic [7:0] {
        chooseOp = 8'h00,
        readToA = 8'h10, readToB = 8'h11, readAddr = 8'h12,
        readLoad = 8'h13, readSettle = 8'h14,
        writeMemA = 8'h20, writeMemB = 8'h21, writeStrobe = 8'h22,
        mathsToA = 8'h30, mathsToB = 8'h31, mathsSettle = 8'h32,
        branchTest = 8'h40, branchTake = 8'h41, branchSettle = 8'h42,
        gotoFetch = 8'h50, gotoLoad = 8'h51, gotoSettle = 8'h52,
        callSave = 8'h60, retWait = 8'h61, retLoad = 8'h62, retSettle = 8'h63,
        derefToA = 8'h70, derefToB = 8'h71, derefAddr = 8'h72,
        derefLoad = 8'h73, derefSettle = 8'h74,
        loadImmToA = 8'h80, loadImmToB = 8'h81, loadImmSettle = 8'h82,
        idle = 8'hF0, threadStart0 = 8'hF1, threadStart1 = 8'hF2, threadStart2 = 8'hF3
    } stateT;

    // Program counter actions
    typedef enum logic [2:0] {
        pcHold, pcPlusOne, pcPlusTwo, pcLoadRom, pcLoadContext, pcLoadVector
    } pcOpT;

    // Register load sources
    typedef enum logic [1:0] {
        srcBus, srcAlu, srcRom
    } regSrcT;

    // Bus address sources
    typedef enum logic [1:0] {
        addrIdle, addrRom, addrRegA, addrRegB
    } busAddrSelT;

    // Control word issued by the FSM every cycle
    typedef struct packed {
        pcOpT pcOp;
        logic fetchOffset;
        logic saveContext;
        logic loadA;
        logic loadB;
        regSrcT regSrc;
        busAddrSelT busAddrSel;
        logic busWrite;
        logic writeFromB;
        byteT vector;
    } ctrlT;

endpackage

// File: logic/microProcessor.sv
`timescale 1ns/1ps

module microProcessor import cpuPkg::*; (
    input logic CLK,
    input logic RESET,
    inout wire byteT busData,
    output byteT busAddr,
    output logic busWe,
    output byteT romAddr,
    input byteT romData,
    input logic [irqCount-1:0] irqRaise,
    output logic [irqCount-1:0] irqAck
);

    // Control word from the FSM
    ctrlT ctrl;
    byteT aluResult;
    byteT regA;
    byteT regB;

    //////////////////////////////////////////////////////////////////////////////
    // Units
    //////////////////////////////////////////////////////////////////////////////

    // Upper ROM nibble picks the ALU function
    aluUnit i_aluUnit (
        .CLK(CLK),
        .RESET(RESET),
        .a(regA),
        .b(regB),
        .op(aluOpT'(romData[dataWidth-1:opWidth])),
        .result(aluResult)
    );

    progSequencer i_progSequencer (
        .CLK(CLK),
        .RESET(RESET),
        .ctrl(ctrl),
        .romData(romData),
        .romAddr(romAddr)
    );

    controlFsm i_controlFsm (
        .CLK(CLK),
        .RESET(RESET),
        .romData(romData),
        .aluResult(aluResult),
        .irqRaise(irqRaise),
        .irqAck(irqAck),
        .ctrl(ctrl)
    );

    // Registers and bus pins
    busDatapath i_busDatapath (
        .CLK(CLK),
        .RESET(RESET),
        .ctrl(ctrl),
        .romData(romData),
        .aluResult(aluResult),
        .busData(busData),
        .busAddr(busAddr),
        .busWe(busWe),
        .regA(regA),
        .regB(regB)
    );

endmodule

// File: logic/progSequencer.sv
`timescale 1ns/1ps

module progSequencer import cpuPkg::*; (
    input logic CLK,
    input logic RESET,
    input ctrlT ctrl,
    input byteT romData,
    output byteT romAddr
);

    // Program counter
    byteT pc;
    // Points the ROM at the operand byte
    logic fetchOffset;
    // Return address saved by a call
    byteT savedContext;

    // ROM address is the instruction or its operand
    assign romAddr = pc + {{(dataWidth-1){1'b0}}, fetchOffset};

    //////////////////////////////////////////////////////////////////////////////
    // Counter update
    //////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge CLK) begin
        if (RESET) begin
            pc <= '0;
            fetchOffset <= 1'b0;
            savedContext <= '0;
        end else begin
            fetchOffset <= ctrl.fetchOffset;
            // Call saves the address after its two bytes
            if (ctrl.saveContext) begin
                savedContext <= pc + byteT'(2);
            end
            case (ctrl.pcOp)
                pcPlusOne: pc <= pc + byteT'(1);
                pcPlusTwo: pc <= pc + byteT'(2);
                // Jump target or thread start read from ROM
                pcLoadRom: pc <= romData;
                pcLoadContext: pc <= savedContext;
                // Interrupt vector cell
                pcLoadVector: pc <= ctrl.vector;
                default: pc <= pc;
            endcase
        end
    end

    // Only one call level so a return never overlaps a save
    noSaveOnReturn: assert property (
        @(posedge CLK) disable iff (RESET)
        !(ctrl.saveContext && ctrl.pcOp == pcLoadContext)
    );

endmodule

// File: microProcessor.f
logic/cpuPkg.sv
logic/aluUnit.sv
logic/progSequencer.sv
logic/controlFsm.sv
logic/busDatapath.sv
logic/microProcessor.sv
bench/busChecker.sv
bench/processorBench.sv
